//--- all.f
+incdir+verilog
verilog/procPkg.sv
verilog/procAlu.sv
verilog/progSequencer.sv
verilog/regDatapath.sv
verilog/procTop.sv
verif/procTb.sv

//--- run.sh
#!/bin/sh
# Build the processor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
LOG=sim.log

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -f all.f --top-module procTb -Mdir "$OBJ" -o procSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/procSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

//--- verif/procPatterns.txt
// Hex bytes at the @ addresses: 000-0FF ROM image, 100-1FF RAM preload
// Test records from 200: line mask, write count, then address and data per write

// Line 0 thread: two reads, add, write A then B
@000
00 10 01 11 04 02 40 03 41
// ALU operations, each result written out
14 02 42 24 02 43 34 02 44 44 02 45
54 02 46 65 03 47 74 02 48 85 03 49
B4 02 4A A5 03 4B C4 02 4C
// Branch taken, branch not taken, goto, end
96 2E 02 50 00 12 96 34 02 51 07 38 03 52 02 53 08

// Line 1 thread: read B, increment B, write B, end
@080
01 13 65 03 60 08

// Start vectors, line 1 then line 0
@0FE
80 00

// RAM bytes 10 to 13
@110
2D 17 5A 3C

// Both lines raised, line 0 served
@200
03 0F 40 44 41 17 42 2D 43 0B 44 16 45 0B 46 0C 47 18
48 0B 49 17 4A 01 4B 00 4C 00 51 5A 53 5A
// Line 1 alone, twice
02 01 60 3D
02 01 60 3D
// Line 0 alone
01 0F 40 44 41 17 42 2D 43 0B 44 16 45 0B 46 0C 47 18
48 0B 49 17 4A 01 4B 00 4C 00 51 5A 53 5A
00

//--- verif/procTb.sv
`timescale 1ns/10ps
`include "proc_config.svh"

module procTb;

    localparam int ackTimeout    = 16;     // Cycles from raise to acknowledge
    localparam int threadTimeout = 400;    // Cycles for a whole thread

    logic                    CLK;
    logic                    RESET;
    logic [`PROC_ADDR_W-1:0] romAddr;
    logic [`PROC_DATA_W-1:0] romData = '0;
    procPkg::busReq_t        busReq;
    logic [`PROC_DATA_W-1:0] busDataIn = '0;
    logic [`PROC_INT_N-1:0]  intRaise;
    logic [`PROC_INT_N-1:0]  intAck;

    logic [7:0]       rom [0:255];
    logic [7:0]       ram [0:255];
    logic [7:0]       romByte;         // ROM byte sampled at the edge
    logic [7:0]       ramByte;         // RAM byte sampled at the edge
    logic [7:0]       pat [0:1023];    // Raw pattern file image
    logic [9:0]       recPtr;          // Next test record
    logic [31:0]      lfsrState;
    int               errors;
    int               testsRun;
    int               testsFailed;
    procPkg::busReq_t expWrites[$];    // Writes the current thread must make

    procTop i_dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .romAddr   (romAddr),
        .romData   (romData),
        .busReq    (busReq),
        .busDataIn (busDataIn),
        .intRaise  (intRaise),
        .intAck    (intAck)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;         // 8 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////////////////////////

    // Registered read driven just after the edge
    always @(posedge CLK) begin
        romByte = rom[romAddr];
        #1;
        romData = romByte;
    end

    // Read data one cycle after the address and write at the strobe edge
    always @(posedge CLK) begin
        ramByte = ram[busReq.addr];
        if (busReq.wrEn) begin
            ram[busReq.addr] = busReq.wrData;
        end
        #1;
        busDataIn = ramByte;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic nextRandomBit();
        logic fb;
        fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkWrite(input procPkg::busReq_t got, input procPkg::busReq_t exp);
        if (got.addr !== exp.addr) begin
            $display("FAILED t=%0t busReq.addr got %h expected %h", $time, got.addr, exp.addr);
            errors++;
        end
        if (got.wrData !== exp.wrData) begin
            $display("FAILED t=%0t busReq.wrData got %h expected %h",
                     $time, got.wrData, exp.wrData);
            errors++;
        end
    endtask

    // Parked address and no strobe
    task automatic checkIdleBus(input procPkg::busReq_t got);
        if (got.addr !== `PROC_IDLE_ADDR) begin
            $display("FAILED t=%0t busReq.addr got %h expected %h",
                     $time, got.addr, `PROC_IDLE_ADDR);
            errors++;
        end
        if (got.wrEn !== 1'b0) begin
            $display("FAILED t=%0t busReq.wrEn got %b expected 0", $time, got.wrEn);
            errors++;
        end
    endtask

    task automatic checkAck(input logic [`PROC_INT_N-1:0] got,
                            input logic [`PROC_INT_N-1:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t intAck got %b expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic checkRomAddr(input logic [`PROC_ADDR_W-1:0] got,
                                input logic [`PROC_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t romAddr got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic finishTest(input string what, input int errBefore);
        testsRun++;
        if (errors == errBefore) begin
            $display("Test %0d %s: ok", testsRun, what);
        end else begin
            testsFailed++;
            $display("Test %0d %s: %0d errors", testsRun, what, errors - errBefore);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test steps
    //////////////////////////////////////////////////////////////////////

    // Quiet bus and no acknowledge while nothing is raised
    task automatic resetTest();
        int errBefore;
        int k;
        errBefore = errors;
        checkAck(intAck, 2'b00);
        checkIdleBus(busReq);
        for (k = 0; k < 10; k++) begin
            @(posedge CLK);
            #1;
            checkAck(intAck, 2'b00);
            checkIdleBus(busReq);
        end
        finishTest("reset and idle", errBefore);
    endtask

    // Loads the next record into mask and expWrites
    // More is 0 at the end marker
    task automatic readRecord(output logic [1:0] mask, output logic more);
        int               count;
        int               n;
        procPkg::busReq_t req;
        mask  = pat[recPtr][1:0];
        more  = (pat[recPtr] != 8'h00) && (recPtr < 10'h3C0);
        count = {24'h0, pat[recPtr + 10'd1]};
        expWrites.delete();
        if (more) begin
            for (n = 0; n < count; n++) begin
                req.addr   = pat[recPtr + 10'd2 + 10'(2 * n)];
                req.wrData = pat[recPtr + 10'd3 + 10'(2 * n)];
                req.wrEn   = 1'b1;
                expWrites.push_back(req);
            end
            recPtr = recPtr + 10'd2 + 10'(2 * count);
        end
    endtask

    // Random gap, raise, acknowledge, then follow the thread back to idle
    task automatic serveInterrupt(input logic [1:0] mask);
        int                      errBefore;
        int                      gap;
        int                      k;
        int                      waitCount;
        int                      got;
        logic [1:0]              expAck;
        logic [`PROC_ADDR_W-1:0] expVec;
        logic                    acked;
        logic                    done;
        errBefore = errors;
        expAck    = mask[0] ? 2'b01 : 2'b10;     // Line 0 has priority
        expVec    = mask[0] ? `PROC_INT0_VEC : `PROC_INT1_VEC;
        gap       = 0;
        for (k = 0; k < 3; k++) begin
            gap = gap * 2 + (nextRandomBit() ? 1 : 0);
        end
        for (k = 0; k < gap; k++) begin
            @(posedge CLK);
            #1;
            checkIdleBus(busReq);
        end
        intRaise  = mask;
        acked     = 1'b0;
        waitCount = 0;
        while (!acked && waitCount < ackTimeout) begin
            @(posedge CLK);
            #1;
            if (intAck != 2'b00) begin
                acked = 1'b1;
            end else begin
                waitCount++;
            end
        end
        if (acked) begin
            checkAck(intAck, expAck);
            checkRomAddr(romAddr, expVec);        // ROM addressed at the vector
        end else begin
            $display("Timeout waiting for intAck after raising lines %b", mask);
            errors++;
        end
        intRaise  = '0;
        got       = 0;
        done      = 1'b0;
        waitCount = 0;
        while (acked && !done && waitCount < threadTimeout) begin
            @(posedge CLK);
            #1;
            waitCount++;
            checkAck(intAck, 2'b00);              // Pulse over and no new wake-up
            if (busReq.wrEn) begin
                if (got < expWrites.size()) begin
                    checkWrite(busReq, expWrites[got]);
                end else begin
                    $display("Unexpected write to %h with data %h at time %0t",
                             busReq.addr, busReq.wrData, $time);
                    errors++;
                end
                got++;
            end
            if (i_dut.i_seq.state == procPkg::S_IDLE) begin
                done = 1'b1;
            end
        end
        if (acked && !done) begin
            $display("Timeout waiting for the thread of lines %b to end", mask);
            errors++;
        end
        if (got != expWrites.size()) begin
            $display("Thread made %0d writes where %0d were expected", got, expWrites.size());
            errors++;
        end
        if (done) begin
            checkIdleBus(busReq);
        end
        finishTest($sformatf("interrupt lines %b", mask), errBefore);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int         i;
        int         j;
        logic [1:0] mask;
        logic       more;
        RESET       = 1'b1;
        intRaise    = '0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        lfsrState   = 32'hdfe72062;
        for (i = 0; i < 1024; i++) begin
            pat[i[9:0]] = i[7:0] ^ {i[9:8], 6'h1B};   // Unused bytes
        end
        $readmemh("verif/procPatterns.txt", pat);
        for (i = 0; i < 256; i++) begin
            j           = i + 256;
            rom[i[7:0]] = pat[i[9:0]];
            ram[i[7:0]] = pat[j[9:0]];
        end

        repeat (5) @(posedge CLK);
        #1;
        RESET = 1'b0;
        resetTest();

        recPtr = 10'h200;
        readRecord(mask, more);
        while (more) begin
            serveInterrupt(mask);
            readRecord(mask, more);
        end
        if (testsRun < 2) begin
            $display("No test records found in the pattern file");
            errors++;
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 testsRun, testsRun - testsFailed, testsFailed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog/procAlu.sv
`timescale 1ns/10ps
`include "proc_config.svh"

// Purely combinational, result follows registers and op
module procAlu (
    input  logic [`PROC_DATA_W-1:0] regA,
    input  logic [`PROC_DATA_W-1:0] regB,
    input  procPkg::aluOp_t         aluOp,
    output logic [`PROC_DATA_W-1:0] aluResult
);

    logic isEq;     // Compare flags
    logic isGt;
    logic isLt;

    assign isEq = (regA == regB);
    assign isGt = (regA > regB);
    assign isLt = (regA < regB);

    //////////////////////////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            procPkg::ADD:   aluResult = regA + regB;
            procPkg::SUB:   aluResult = regA - regB;
            procPkg::MUL:   aluResult = regA * regB;      // Wraps to low byte
            // Single bit shifts on A only
            procPkg::SHL_A: aluResult = regA << 1;
            procPkg::SHR_A: aluResult = regA >> 1;
            procPkg::INC_A: aluResult = regA + 1;
            procPkg::INC_B: aluResult = regB + 1;
            procPkg::DEC_A: aluResult = regA - 1;
            procPkg::DEC_B: aluResult = regB - 1;
            // Compares feed the branch decision
            procPkg::EQ: begin
                aluResult = {{(`PROC_DATA_W-1){1'b0}}, isEq};
            end
            procPkg::GT: begin
                aluResult = {{(`PROC_DATA_W-1){1'b0}}, isGt};
            end
            procPkg::LT: begin
                aluResult = {{(`PROC_DATA_W-1){1'b0}}, isLt};
            end
            default: begin
                aluResult = '0;                           // Codes C to F
            end
        endcase
    end

endmodule

//--- verilog/procPkg.sv
`include "proc_config.svh"

package procPkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////////////////////////

    // Low nibble of an instruction byte
    typedef enum logic [3:0] {
        READ_A     = 4'h0,     // Memory to A
        READ_B     = 4'h1,     // Memory to B
        WRITE_A    = 4'h2,     // A to memory
        WRITE_B    = 4'h3,     // B to memory
        MATHS_A    = 4'h4,     // ALU result into A
        MATHS_B    = 4'h5,     // ALU result into B
        BRANCH     = 4'h6,     // Jump if ALU result nonzero
        GOTO       = 4'h7,     // Unconditional jump
        END_THREAD = 4'h8      // Back to sleep
    } opcode_t;

    // High nibble of an instruction byte
    typedef enum logic [3:0] {
        ADD   = 4'h0,
        SUB   = 4'h1,          // A minus B
        MUL   = 4'h2,          // Low byte only
        SHL_A = 4'h3,
        SHR_A = 4'h4,
        INC_A = 4'h5,
        INC_B = 4'h6,
        DEC_A = 4'h7,
        DEC_B = 4'h8,
        EQ    = 4'h9,          // Compares give 1 or 0
        GT    = 4'hA,
        LT    = 4'hB
    } aluOp_t;

    // Sequencer FSM states
    typedef enum logic [4:0] {
        S_IDLE, S_THREAD_0, S_THREAD_1, S_THREAD_2, S_DECODE,
        S_READ_A, S_READ_B, S_READ_0, S_READ_1, S_READ_2,
        S_WRITE_A, S_WRITE_B, S_WRITE_0,
        S_MATHS_A, S_MATHS_B, S_MATHS_0,
        S_BRANCH, S_BRANCH_0, S_BRANCH_1,
        S_GOTO, S_GOTO_0, S_GOTO_1
    } seqState_t;

    // Per-cycle command from sequencer to datapath
    typedef enum logic [2:0] {
        NONE, SET_ADDR, LOAD_A_BUS, LOAD_B_BUS,
        LOAD_A_ALU, LOAD_B_ALU, STORE_A, STORE_B
    } dpAction_t;

    // Registered data bus request
    typedef struct packed {
        logic [`PROC_ADDR_W-1:0] addr;
        logic [`PROC_DATA_W-1:0] wrData;
        logic                    wrEn;
    } busReq_t;

endpackage

//--- verilog/procTop.sv
`timescale 1ns/10ps
`include "proc_config.svh"

module procTop (
    input  logic                    CLK,
    input  logic                    RESET,
    output logic [`PROC_ADDR_W-1:0] romAddr,
    input  logic [`PROC_DATA_W-1:0] romData,    // One cycle after romAddr
    output procPkg::busReq_t        busReq,
    input  logic [`PROC_DATA_W-1:0] busDataIn,  // One cycle after busReq address
    input  logic [`PROC_INT_N-1:0]  intRaise,
    output logic [`PROC_INT_N-1:0]  intAck
);

    //////////////////////////////////////////////////////////////////////
    // Internal wiring
    //////////////////////////////////////////////////////////////////////

    procPkg::aluOp_t         aluOp;
    procPkg::dpAction_t      dpAction;
    logic [`PROC_DATA_W-1:0] regA;
    logic [`PROC_DATA_W-1:0] regB;
    logic [`PROC_DATA_W-1:0] aluResult;   // Shared by sequencer and datapath

    progSequencer i_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .romData   (romData),
        .intRaise  (intRaise),
        .aluResult (aluResult),
        .romAddr   (romAddr),
        .aluOp     (aluOp),
        .dpAction  (dpAction),
        .intAck    (intAck)
    );

    procAlu i_alu (
        .regA      (regA),
        .regB      (regB),
        .aluOp     (aluOp),
        .aluResult (aluResult)
    );

    // Datapath takes ROM operand bytes directly
    regDatapath i_dp (
        .CLK       (CLK),
        .RESET     (RESET),
        .dpAction  (dpAction),
        .romData   (romData),
        .aluResult (aluResult),
        .busDataIn (busDataIn),
        .regA      (regA),
        .regB      (regB),
        .busReq    (busReq)
    );

endmodule

//--- verilog/proc_config.svh
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

// Register and bus data width
`define PROC_DATA_W 8

// ROM address and data bus address width
`define PROC_ADDR_W 8

//////////////////////////////////////////////////////////////////////
// Interrupts and fixed addresses
//////////////////////////////////////////////////////////////////////

`define PROC_INT_N 2           // Interrupt request lines

// ROM locations holding the thread start address per line
`define PROC_INT0_VEC 8'hFF
`define PROC_INT1_VEC 8'hFE

// Parked bus address when no access runs
// Also the program counter value while sleeping
`define PROC_IDLE_ADDR 8'hFF

`endif

//--- verilog/progSequencer.sv
`timescale 1ns/10ps
`include "proc_config.svh"

module progSequencer (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic [`PROC_DATA_W-1:0] romData,     // Byte at last cycle's romAddr
    input  logic [`PROC_INT_N-1:0]  intRaise,
    input  logic [`PROC_DATA_W-1:0] aluResult,
    output logic [`PROC_ADDR_W-1:0] romAddr,
    output procPkg::aluOp_t         aluOp,
    output procPkg::dpAction_t      dpAction,
    output logic [`PROC_INT_N-1:0]  intAck
);

    procPkg::seqState_t      state;
    procPkg::seqState_t      nextState;
    logic [`PROC_ADDR_W-1:0] progCounter;
    logic [`PROC_ADDR_W-1:0] nextPc;
    logic [1:0]              pcOffset;   // Reaches operand bytes
    logic [1:0]              nextOffset;
    procPkg::aluOp_t         nextAluOp;
    logic                    regSel;     // 0 for A and 1 for B
    logic                    nextRegSel;
    logic [`PROC_INT_N-1:0]  nextAck;
    procPkg::opcode_t        opcode;

    assign opcode  = procPkg::opcode_t'(romData[3:0]);
    assign romAddr = progCounter + {{(`PROC_ADDR_W-2){1'b0}}, pcOffset};

    //////////////////////////////////////////////////////////////////////
    // State registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state       <= procPkg::S_IDLE;   // Sleep until woken
            progCounter <= `PROC_IDLE_ADDR;
            pcOffset    <= '0;
            aluOp       <= procPkg::ADD;
            regSel      <= 1'b0;
            intAck      <= '0;
        end else begin
            state       <= nextState;
            progCounter <= nextPc;
            pcOffset    <= nextOffset;
            aluOp       <= nextAluOp;
            regSel      <= nextRegSel;
            intAck      <= nextAck;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state and datapath command
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState  = state;
        nextPc     = progCounter;
        nextOffset = '0;          // Back to the opcode byte by default
        nextAluOp  = aluOp;
        nextRegSel = regSel;
        nextAck    = '0;
        dpAction   = procPkg::NONE;

        case (state)
            // Sleeping, line 0 has priority
            procPkg::S_IDLE: begin
                nextPc = `PROC_IDLE_ADDR;
                if (intRaise[0]) begin
                    nextState  = procPkg::S_THREAD_0;
                    nextPc     = `PROC_INT0_VEC;
                    nextAck[0] = 1'b1;
                end else if (intRaise[1]) begin
                    nextState  = procPkg::S_THREAD_0;
                    nextPc     = `PROC_INT1_VEC;
                    nextAck[1] = 1'b1;
                end
            end
            procPkg::S_THREAD_0: nextState = procPkg::S_THREAD_1;  // Vector on ROM address
            procPkg::S_THREAD_1: begin
                nextPc    = romData;                             // Thread start address
                nextState = procPkg::S_THREAD_2;
            end
            procPkg::S_THREAD_2: nextState = procPkg::S_DECODE;    // First opcode on its way

            // Opcode byte is on romData here
            procPkg::S_DECODE: begin
                nextOffset = 2'd1;                                 // Fetch operand next
                nextAluOp  = procPkg::aluOp_t'(romData[7:4]);
                case (opcode)
                    procPkg::READ_A:  nextState = procPkg::S_READ_A;
                    procPkg::READ_B:  nextState = procPkg::S_READ_B;
                    procPkg::WRITE_A: nextState = procPkg::S_WRITE_A;
                    procPkg::WRITE_B: nextState = procPkg::S_WRITE_B;
                    procPkg::MATHS_A: nextState = procPkg::S_MATHS_A;
                    procPkg::MATHS_B: nextState = procPkg::S_MATHS_B;
                    procPkg::BRANCH:  nextState = procPkg::S_BRANCH;
                    procPkg::GOTO:    nextState = procPkg::S_GOTO;
                    default:          nextState = procPkg::S_IDLE; // END_THREAD or unknown
                endcase
            end

            // Memory read into A or B
            procPkg::S_READ_A: begin
                nextRegSel = 1'b0;
                nextState  = procPkg::S_READ_0;
            end
            procPkg::S_READ_B: begin
                nextRegSel = 1'b1;
                nextState  = procPkg::S_READ_0;
            end
            procPkg::S_READ_0: begin
                dpAction  = procPkg::SET_ADDR;                    // Address byte on romData
                nextState = procPkg::S_READ_1;
            end
            procPkg::S_READ_1: begin
                nextPc    = progCounter + 2;                      // Two cycles ahead of decode
                nextState = procPkg::S_READ_2;
            end
            procPkg::S_READ_2: begin
                dpAction  = regSel ? procPkg::LOAD_B_BUS : procPkg::LOAD_A_BUS;
                nextState = procPkg::S_DECODE;
            end

            // Memory write from A or B
            procPkg::S_WRITE_A: begin
                nextRegSel = 1'b0;
                nextPc     = progCounter + 2;
                nextState  = procPkg::S_WRITE_0;
            end
            procPkg::S_WRITE_B: begin
                nextRegSel = 1'b1;
                nextPc     = progCounter + 2;
                nextState  = procPkg::S_WRITE_0;
            end
            procPkg::S_WRITE_0: begin
                dpAction  = regSel ? procPkg::STORE_B : procPkg::STORE_A;
                nextState = procPkg::S_DECODE;                    // Enable shows during decode
            end

            // ALU result back into a register
            procPkg::S_MATHS_A: begin
                dpAction  = procPkg::LOAD_A_ALU;
                nextPc    = progCounter + 1;
                nextState = procPkg::S_MATHS_0;
            end
            procPkg::S_MATHS_B: begin
                dpAction  = procPkg::LOAD_B_ALU;
                nextPc    = progCounter + 1;
                nextState = procPkg::S_MATHS_0;
            end
            procPkg::S_MATHS_0: nextState = procPkg::S_DECODE;

            // Branch on nonzero compare result
            procPkg::S_BRANCH: begin
                if (aluResult != '0) begin
                    nextState = procPkg::S_BRANCH_0;
                end else begin
                    nextPc    = progCounter + 2;                  // Fall through
                    nextState = procPkg::S_BRANCH_1;
                end
            end
            procPkg::S_BRANCH_0: begin
                nextPc    = romData;                              // Target byte
                nextState = procPkg::S_BRANCH_1;
            end
            procPkg::S_BRANCH_1: nextState = procPkg::S_DECODE;

            //////////////////////////////////////////////////////////////
            // Unconditional jump
            procPkg::S_GOTO:     nextState = procPkg::S_GOTO_0;   // Target still in flight
            procPkg::S_GOTO_0: begin
                nextPc    = romData;
                nextState = procPkg::S_GOTO_1;
            end
            procPkg::S_GOTO_1:   nextState = procPkg::S_DECODE;

            default: nextState = procPkg::S_IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Only one line acknowledged at a time
    ackOneHot: assert property (@(posedge CLK) disable iff (RESET)
        $onehot0(intAck));

    // Acknowledge is a single cycle pulse
    ackPulse: assert property (@(posedge CLK) disable iff (RESET)
        (intAck != '0) |=> (intAck == '0));

endmodule

//--- verilog/regDatapath.sv
`timescale 1ns/10ps
`include "proc_config.svh"

module regDatapath (
    input  logic                    CLK,
    input  logic                    RESET,
    input  procPkg::dpAction_t      dpAction,
    input  logic [`PROC_DATA_W-1:0] romData,     // Operand byte used as bus address
    input  logic [`PROC_DATA_W-1:0] aluResult,
    input  logic [`PROC_DATA_W-1:0] busDataIn,
    output logic [`PROC_DATA_W-1:0] regA,
    output logic [`PROC_DATA_W-1:0] regB,
    output procPkg::busReq_t        busReq
);

    logic [`PROC_DATA_W-1:0] nextA;
    logic [`PROC_DATA_W-1:0] nextB;
    procPkg::busReq_t        nextReq;

    //////////////////////////////////////////////////////////////////////
    // Action decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nextA          = regA;
        nextB          = regB;
        nextReq.addr   = `PROC_IDLE_ADDR;     // Park unless an access runs
        nextReq.wrData = busReq.wrData;       // Last written byte held
        nextReq.wrEn   = 1'b0;

        case (dpAction)
            procPkg::SET_ADDR:   nextReq.addr = romData;   // Read address
            procPkg::LOAD_A_BUS: nextA = busDataIn;
            procPkg::LOAD_B_BUS: nextB = busDataIn;
            procPkg::LOAD_A_ALU: nextA = aluResult;
            procPkg::LOAD_B_ALU: nextB = aluResult;
            procPkg::STORE_A: begin
                nextReq.addr   = romData;
                nextReq.wrData = regA;
                nextReq.wrEn   = 1'b1;
            end
            procPkg::STORE_B: begin
                nextReq.addr   = romData;
                nextReq.wrData = regB;
                nextReq.wrEn   = 1'b1;
            end
            default: begin
                nextReq.wrEn = 1'b0;                    // NONE
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA   <= '0;
            regB   <= '0;
            busReq <= '{addr: `PROC_IDLE_ADDR, wrData: '0, wrEn: 1'b0};
        end else begin
            regA   <= nextA;
            regB   <= nextB;
            busReq <= nextReq;
        end
    end

    // Writes are single cycle strobes
    wrEnPulse: assert property (@(posedge CLK) disable iff (RESET)
        busReq.wrEn |=> !busReq.wrEn);

    // Bus data is only taken two cycles after the sequencer set an address
    loadAfterAddr: assert property (@(posedge CLK) disable iff (RESET)
        (dpAction inside {procPkg::LOAD_A_BUS, procPkg::LOAD_B_BUS})
        |-> ($past(dpAction, 2) == procPkg::SET_ADDR));

endmodule
